// File: bench/host_event_props.sv
// Wishbone handshake assertions for the configuration decoder, with bind
`timescale 1ns/1ps
`default_nettype none

module host_event_props (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input host_cfg_pkg::wb_req_t wb_req_i,
  input host_cfg_pkg::wb_rsp_t wb_rsp_i
);

  logic accepted;

  assign accepted = wb_req_i.cyc & wb_req_i.stb & ~wb_rsp_i.ack;

  ack_after_request: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) accepted |=> wb_rsp_i.ack
  ) else $error("ack missing one cycle after an accepted request");

  ack_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) wb_rsp_i.ack |=> !wb_rsp_i.ack
  ) else $error("ack held high for two cycles");

  ack_needs_cyc: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) wb_rsp_i.ack |-> wb_req_i.cyc
  ) else $error("ack high without cyc");

endmodule

bind wb_cfg_decoder host_event_props u_host_event_props (
  .clk_i    ( clk_i    ),
  .rst_n_i  ( rst_n_i  ),
  .wb_req_i ( wb_req_i ),
  .wb_rsp_i ( wb_rsp_o )
);

`default_nettype wire

// File: bench/host_event_tb.sv
// Testbench for host_event_top with file-driven stimulus, shadow model and timeout
`timescale 1ns/1ps
`default_nettype none

module host_event_tb;

  import host_cfg_pkg::*;
  import host_event_pkg::*;

  localparam int unsigned MAX_RECORDS  = 128;
  localparam int unsigned RESET_CYCLES = 8;

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  llc_events_t llc_events;
  logic        dma_valid;
  logic        dma_ack;
  logic        counter_irq;
  logic        doorbell_irq;
  logic        completion_irq;

  // Four hex words per testdata line
  logic [31:0] records [0:4*MAX_RECORDS-1];
  int unsigned num_lines;
  int unsigned cycle_limit = 0;
  int unsigned cycle_count;

  // Shadow state of the register map
  logic [31:0] m_cnt [0:NUM_COUNTERS-1];
  logic [31:0] m_threshold;
  logic [4:0]  m_enable;
  logic        m_doorbell;
  logic        m_completion;
  logic [31:0] m_scratch;
  logic        m_level;

  host_event_top DUT (
    .clk_i              ( clk            ),
    .rst_n_i            ( rst_n          ),
    .wb_req_i           ( wb_req         ),
    .wb_rsp_o           ( wb_rsp         ),
    .llc_events_i       ( llc_events     ),
    .dma_pe_evt_valid_i ( dma_valid      ),
    .dma_pe_evt_ack_o   ( dma_ack        ),
    .counter_irq_o      ( counter_irq    ),
    .doorbell_irq_o     ( doorbell_irq   ),
    .completion_irq_o   ( completion_irq )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_limit != 0 && cycle_count > cycle_limit) begin
        $display("Timeout: the run went past %0d cycles", cycle_limit);
        $display("TEST FAIL");
        $fatal(1);
      end
    end
  end

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error: time %0t, signal %s, expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // File values must agree with the shadow model
  task automatic cross_check(input string what, input logic [31:0] from_file,
                             input logic [31:0] from_model);
    assert (from_file === from_model) else
      fail_with($sformatf("Testdata %s value 0x%08h disagrees with the model value 0x%08h",
                          what, from_file, from_model));
  endtask

  function automatic logic [31:0] sat_add(input logic [31:0] a, input int unsigned n);
    logic [32:0] sum;
    sum = {1'b0, a} + 33'(n);
    return sum[32] ? '1 : sum[31:0];
  endfunction

  function automatic logic model_irq();
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      if (m_enable[i] && m_cnt[i] >= m_threshold) hit = 1'b1;
    end
    return (m_threshold != '0) && hit;
  endfunction

  function automatic logic [31:0] model_read(input logic [5:0] adr);
    logic [3:0] idx;
    idx = adr[3:0];
    model_read = '0;
    if (adr[5:4] == REGION_COUNTERS) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (idx == 4'(i)) model_read = m_cnt[i];
      end
      if (idx == CNT_THRESHOLD) model_read = m_threshold;
      if (idx == CNT_ENABLE) model_read = {27'd0, m_enable};
      if (idx == CNT_STATUS) model_read = {31'd0, model_irq()};
    end else if (adr[5:4] == REGION_MAILBOX) begin
      if (idx == MBX_DOORBELL) model_read = {31'd0, m_doorbell};
      if (idx == MBX_COMPLETION) model_read = {31'd0, m_completion};
      if (idx == MBX_SCRATCH) model_read = m_scratch;
    end
  endfunction

  task automatic model_write(input logic [5:0] adr, input logic [31:0] data);
    logic [3:0] idx;
    idx = adr[3:0];
    if (adr[5:4] == REGION_COUNTERS) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (idx == 4'(i)) m_cnt[i] = '0;
      end
      if (idx == CNT_THRESHOLD) m_threshold = data;
      if (idx == CNT_ENABLE) m_enable = data[4:0];
    end else if (adr[5:4] == REGION_MAILBOX) begin
      if (idx == MBX_DOORBELL && data[0]) m_doorbell = 1'b1;
      if (idx == MBX_COMPLETION && data[0]) m_completion = 1'b1;
      if (idx == MBX_IRQ_CLEAR && data[0]) m_doorbell = 1'b0;
      if (idx == MBX_IRQ_CLEAR && data[1]) m_completion = 1'b0;
      if (idx == MBX_SCRATCH) m_scratch = data;
    end
  endtask

  // Holds cyc and stb until ack, drops them in the cycle after
  task automatic wb_access(input logic we, input logic [5:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int unsigned waited;
    waited = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdata;
    do begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 8) fail_with("No Wishbone ack within 8 cycles of the request");
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat;
    @(posedge clk);
    #1;
    wb_req = '0;
  endtask

  task automatic run_burst(input logic [3:0] bits, input int unsigned cycles);
    llc_events = bits;
    repeat (cycles) @(posedge clk);
    #1;
    llc_events = '0;
    for (int i = 0; i < 4; i++) begin
      if (bits[i] && m_enable[i]) m_cnt[i] = sat_add(m_cnt[i], cycles);
    end
  endtask

  task automatic cluster_toggle();
    int unsigned waited;
    waited = 0;
    dma_valid = ~dma_valid;
    m_level = dma_valid;
    while (dma_ack !== m_level) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 10) fail_with("dma_pe_evt_ack_o did not follow the toggle in 10 cycles");
    end
    // Pulse and counter update land on the next two edges
    repeat (2) @(posedge clk);
    #1;
    if (m_enable[4]) m_cnt[4] = sat_add(m_cnt[4], 1);
  endtask

  task automatic check_irqs(input logic cnt_exp, input logic db_exp, input logic cmp_exp);
    cross_check("counter_irq_o", 32'(cnt_exp), 32'(model_irq()));
    cross_check("doorbell_irq_o", 32'(db_exp), 32'(m_doorbell));
    cross_check("completion_irq_o", 32'(cmp_exp), 32'(m_completion));
    check_value("counter_irq_o", 32'(cnt_exp), 32'(counter_irq));
    check_value("doorbell_irq_o", 32'(db_exp), 32'(doorbell_irq));
    check_value("completion_irq_o", 32'(cmp_exp), 32'(completion_irq));
    check_value("dma_pe_evt_ack_o", 32'(m_level), 32'(dma_ack));
  endtask

  initial begin
    logic [31:0] op;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] rdata;
    rst_n      = 1'b0;
    wb_req     = '0;
    llc_events = '0;
    dma_valid  = 1'b0;
    for (int i = 0; i < NUM_COUNTERS; i++) m_cnt[i] = '0;
    m_threshold  = '0;
    m_enable     = '0;
    m_doorbell   = 1'b0;
    m_completion = 1'b0;
    m_scratch    = '0;
    m_level      = 1'b0;
    $readmemh("bench/host_event_testdata.txt", records);
    num_lines = 0;
    while (num_lines < MAX_RECORDS && !$isunknown(records[4*num_lines]) &&
           records[4*num_lines] != 32'd0) begin
      num_lines++;
    end
    if (num_lines == 0) fail_with("No operations found in the testdata file");
    cycle_limit = num_lines * 64 + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int n = 0; n < num_lines; n++) begin
      op = records[4*n];
      f1 = records[4*n+1];
      f2 = records[4*n+2];
      f3 = records[4*n+3];
      case (op)
        32'd1: begin
          model_write(f1[5:0], f2);
          wb_access(1'b1, f1[5:0], f2, rdata);
        end
        32'd2: begin
          cross_check("read", f2, model_read(f1[5:0]));
          wb_access(1'b0, f1[5:0], '0, rdata);
          check_value($sformatf("wb_rsp_o.dat @ 0x%02h", f1[5:0]), f2, rdata);
        end
        32'd3: run_burst(f1[3:0], int'(f2));
        32'd4: cluster_toggle();
        32'd5: check_irqs(f1[0], f2[0], f3[0]);
        default: fail_with($sformatf("Unknown operation %0d on testdata line %0d", op, n));
      endcase
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/host_event_testdata.txt
// Columns: op, address or bits, data or cycles, spare; all hex, unused columns zero
// op 1 write, 2 read with expected data, 3 LLC burst, 4 cluster toggle, 5 irq check, 0 end
5 0 0 0
2 00 00000000 0
2 08 00000000 0
2 09 00000000 0
2 0a 00000000 0
2 11 00000000 0
2 13 00000000 0
1 09 0000001b 0
3 3 0c 0
3 c 07 0
2 00 0000000c 0
2 02 00000000 0
2 03 00000007 0
1 01 00000000 0
2 01 00000000 0
1 08 00000010 0
3 1 04 0
5 1 0 0
2 0a 00000001 0
1 00 00000000 0
5 0 0 0
3 1 14 0
5 1 0 0
1 08 00000000 0
5 0 0 0
1 10 fffffffe 0
5 0 0 0
1 10 00000001 0
1 11 00000001 0
5 0 1 1
2 10 00000001 0
1 12 00000001 0
5 0 0 1
2 11 00000001 0
1 12 00000002 0
5 0 0 0
1 13 a5c3e10f 0
4 0 0 0
4 0 0 0
5 0 0 0
2 04 00000002 0
1 25 ffffffff 0
1 0a ffffffff 0
2 25 00000000 0
2 3f 00000000 0
2 13 a5c3e10f 0
2 09 0000001b 0
0 0 0 0

// File: filelist.f
verilog/host_cfg_pkg.sv
verilog/host_event_pkg.sv
verilog/wb_cfg_decoder.sv
verilog/event_counter_bank.sv
verilog/mailbox_regs.sv
verilog/cluster_evt_rx.sv
verilog/host_event_top.sv
bench/host_event_props.sv
bench/host_event_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module host_event_tb \
  -o host_event_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/host_event_sim > sim.log 2>&1
cat sim.log
grep -q "^TEST PASS$" sim.log && exit 0 || exit 1

// File: verilog/cluster_evt_rx.sv
// Two-phase cluster event receiver with synchronizer, acknowledge and event pulse
`timescale 1ns/1ps
`default_nettype none

module cluster_evt_rx (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic pulse_o
);

  logic sync1_q;
  logic sync2_q;
  logic level_q;
  logic pulse_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      level_q <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync1_q <= valid_i;
      sync2_q <= sync1_q;
      level_q <= sync2_q;
      // Any change of the synchronized level is one event
      pulse_q <= sync2_q ^ level_q;
    end
  end

  // Cluster may toggle again once ack equals its level
  assign ack_o   = sync2_q;
  assign pulse_o = pulse_q;

endmodule

`default_nettype wire

// File: verilog/event_counter_bank.sv
// Saturating event counters with enable mask, clear on write and threshold interrupt
`timescale 1ns/1ps
`default_nettype none

module event_counter_bank (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  host_cfg_pkg::reg_access_t           access_i,
  input  host_event_pkg::event_vec_t          events_i,
  output logic [host_cfg_pkg::CFG_DATA_W-1:0] rdata_o,
  output logic                                counter_irq_o
);

  import host_cfg_pkg::*;
  import host_event_pkg::*;

  logic [NUM_COUNTERS-1:0][COUNTER_W-1:0] cnt_q;
  logic [COUNTER_W-1:0]                   threshold_q;
  logic [NUM_COUNTERS-1:0]                enable_q;
  logic [NUM_COUNTERS-1:0]                evt_bits;
  logic [NUM_COUNTERS-1:0]                clr;
  logic [NUM_COUNTERS-1:0]                at_threshold;

  assign evt_bits = events_i;

  always_comb begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      clr[i]          = access_i.we && (access_i.index == REG_INDEX_W'(i));
      at_threshold[i] = enable_q[i] && (cnt_q[i] >= threshold_q);
    end
  end

  // Clear wins over a same-cycle increment
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (clr[i]) begin
          cnt_q[i] <= '0;
        end else if (evt_bits[i] && enable_q[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + COUNTER_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      threshold_q <= '0;
      enable_q    <= '0;
    end else if (access_i.we) begin
      if (access_i.index == CNT_THRESHOLD) begin
        threshold_q <= access_i.wdata;
      end
      if (access_i.index == CNT_ENABLE) begin
        enable_q <= access_i.wdata[NUM_COUNTERS-1:0];
      end
    end
  end

  // Zero threshold disables the interrupt
  assign counter_irq_o = (threshold_q != '0) && (|at_threshold);

  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      if (access_i.index == REG_INDEX_W'(i)) begin
        rdata_o = cnt_q[i];
      end
    end
    case (access_i.index)
      CNT_THRESHOLD: rdata_o = threshold_q;
      CNT_ENABLE:    rdata_o = {{(CFG_DATA_W-NUM_COUNTERS){1'b0}}, enable_q};
      CNT_STATUS:    rdata_o = {{(CFG_DATA_W-1){1'b0}}, counter_irq_o};
      default:       ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/host_cfg_pkg.sv
// Configuration bus structs, word-address map, region and mailbox indexes
`default_nettype none

package host_cfg_pkg;

  localparam int unsigned CFG_ADDR_W  = 6;
  localparam int unsigned CFG_DATA_W  = 32;
  localparam int unsigned REG_INDEX_W = 4;
  localparam int unsigned REGION_W    = CFG_ADDR_W - REG_INDEX_W;

  // Upper address bits select the region, 2 and 3 are unmapped
  localparam logic [REGION_W-1:0] REGION_COUNTERS = 2'd0;
  localparam logic [REGION_W-1:0] REGION_MAILBOX  = 2'd1;

  localparam logic [REG_INDEX_W-1:0] MBX_DOORBELL   = 4'd0;
  localparam logic [REG_INDEX_W-1:0] MBX_COMPLETION = 4'd1;
  localparam logic [REG_INDEX_W-1:0] MBX_IRQ_CLEAR  = 4'd2;
  localparam logic [REG_INDEX_W-1:0] MBX_SCRATCH    = 4'd3;

  // Wishbone classic master side, word addressed
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [CFG_ADDR_W-1:0] adr;
    logic [CFG_DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic [CFG_DATA_W-1:0] dat;
  } wb_rsp_t;

  // Per-region access, strobe already qualified by region
  typedef struct packed {
    logic                   we;
    logic [REG_INDEX_W-1:0] index;
    logic [CFG_DATA_W-1:0]  wdata;
  } reg_access_t;

endpackage

`default_nettype wire

// File: verilog/host_event_pkg.sv
// Event vector structs, counter dimensions and counter register indexes
`default_nettype none

package host_event_pkg;

  localparam int unsigned NUM_COUNTERS = 5;
  localparam int unsigned COUNTER_W    = 32;

  // Counter i sits at index i, control registers above them
  localparam logic [host_cfg_pkg::REG_INDEX_W-1:0] CNT_THRESHOLD = 4'd8;
  localparam logic [host_cfg_pkg::REG_INDEX_W-1:0] CNT_ENABLE    = 4'd9;
  localparam logic [host_cfg_pkg::REG_INDEX_W-1:0] CNT_STATUS    = 4'd10;

  // LLC hit and miss events, read hit in bit 0
  typedef struct packed {
    logic write_miss;
    logic write_hit;
    logic read_miss;
    logic read_hit;
  } llc_events_t;

  // Bit i feeds counter i
  typedef struct packed {
    logic        cluster_dma;
    llc_events_t llc;
  } event_vec_t;

endpackage

`default_nettype wire

// File: verilog/host_event_top.sv
// Host event top with config decoder, counter bank, mailbox and cluster event receiver
`timescale 1ns/1ps
`default_nettype none

module host_event_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  host_cfg_pkg::wb_req_t       wb_req_i,
  output host_cfg_pkg::wb_rsp_t       wb_rsp_o,
  input  host_event_pkg::llc_events_t llc_events_i,
  input  logic                        dma_pe_evt_valid_i,
  output logic                        dma_pe_evt_ack_o,
  output logic                        counter_irq_o,
  output logic                        doorbell_irq_o,
  output logic                        completion_irq_o
);

  import host_cfg_pkg::*;
  import host_event_pkg::*;

  reg_access_t           cnt_access;
  reg_access_t           mbx_access;
  logic [CFG_DATA_W-1:0] cnt_rdata;
  logic [CFG_DATA_W-1:0] mbx_rdata;
  logic                  dma_evt_pulse;
  event_vec_t            events;

  assign events.llc         = llc_events_i;
  assign events.cluster_dma = dma_evt_pulse;

  wb_cfg_decoder i_wb_cfg_decoder (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .wb_req_i     ( wb_req_i   ),
    .wb_rsp_o     ( wb_rsp_o   ),
    .cnt_access_o ( cnt_access ),
    .mbx_access_o ( mbx_access ),
    .cnt_rdata_i  ( cnt_rdata  ),
    .mbx_rdata_i  ( mbx_rdata  )
  );

  event_counter_bank i_event_counter_bank (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .access_i      ( cnt_access    ),
    .events_i      ( events        ),
    .rdata_o       ( cnt_rdata     ),
    .counter_irq_o ( counter_irq_o )
  );

  mailbox_regs i_mailbox_regs (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .access_i         ( mbx_access       ),
    .rdata_o          ( mbx_rdata        ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

  cluster_evt_rx i_cluster_evt_rx (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .pulse_o ( dma_evt_pulse      )
  );

endmodule

`default_nettype wire

// File: verilog/mailbox_regs.sv
// Doorbell and completion mailbox registers with scratch word and two interrupts
`timescale 1ns/1ps
`default_nettype none

module mailbox_regs (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  host_cfg_pkg::reg_access_t           access_i,
  output logic [host_cfg_pkg::CFG_DATA_W-1:0] rdata_o,
  output logic                                doorbell_irq_o,
  output logic                                completion_irq_o
);

  import host_cfg_pkg::*;

  logic                  doorbell_q;
  logic                  completion_q;
  logic [CFG_DATA_W-1:0] scratch_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      doorbell_q   <= 1'b0;
      completion_q <= 1'b0;
      scratch_q    <= '0;
    end else if (access_i.we) begin
      case (access_i.index)
        MBX_DOORBELL: begin
          if (access_i.wdata[0]) doorbell_q <= 1'b1;
        end
        MBX_COMPLETION: begin
          if (access_i.wdata[0]) completion_q <= 1'b1;
        end
        MBX_IRQ_CLEAR: begin
          // Each pending bit clears on its own
          if (access_i.wdata[0]) doorbell_q <= 1'b0;
          if (access_i.wdata[1]) completion_q <= 1'b0;
        end
        MBX_SCRATCH: scratch_q <= access_i.wdata;
        default: ;
      endcase
    end
  end

  assign doorbell_irq_o   = doorbell_q;
  assign completion_irq_o = completion_q;

  always_comb begin
    case (access_i.index)
      MBX_DOORBELL:   rdata_o = {{(CFG_DATA_W-1){1'b0}}, doorbell_q};
      MBX_COMPLETION: rdata_o = {{(CFG_DATA_W-1){1'b0}}, completion_q};
      MBX_SCRATCH:    rdata_o = scratch_q;
      default:        rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/wb_cfg_decoder.sv
// Wishbone classic slave splitting accesses into counter and mailbox regions
`timescale 1ns/1ps
`default_nettype none

module wb_cfg_decoder (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  host_cfg_pkg::wb_req_t               wb_req_i,
  output host_cfg_pkg::wb_rsp_t               wb_rsp_o,
  output host_cfg_pkg::reg_access_t           cnt_access_o,
  output host_cfg_pkg::reg_access_t           mbx_access_o,
  input  logic [host_cfg_pkg::CFG_DATA_W-1:0] cnt_rdata_i,
  input  logic [host_cfg_pkg::CFG_DATA_W-1:0] mbx_rdata_i
);

  import host_cfg_pkg::*;

  logic [REGION_W-1:0]    region;
  logic [REG_INDEX_W-1:0] index;
  logic                   accept;
  logic                   ack_q;
  logic [CFG_DATA_W-1:0]  rdata_d;
  logic [CFG_DATA_W-1:0]  rdata_q;

  assign region = wb_req_i.adr[CFG_ADDR_W-1 -: REGION_W];
  assign index  = wb_req_i.adr[REG_INDEX_W-1:0];

  // New access is taken once the previous ack is gone
  assign accept = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  always_comb begin
    cnt_access_o.we    = accept & wb_req_i.we & (region == REGION_COUNTERS);
    cnt_access_o.index = index;
    cnt_access_o.wdata = wb_req_i.dat;
    mbx_access_o.we    = accept & wb_req_i.we & (region == REGION_MAILBOX);
    mbx_access_o.index = index;
    mbx_access_o.wdata = wb_req_i.dat;
  end

  // Unmapped regions read as zero
  always_comb begin
    case (region)
      REGION_COUNTERS: rdata_d = cnt_rdata_i;
      REGION_MAILBOX:  rdata_d = mbx_rdata_i;
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q <= accept;
      if (accept) begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire
